// File: src.f
+incdir+hw
hw/spiMemoryPkg.sv
hw/inputConditioner.sv
hw/shiftRegister.sv
hw/spiControl.sv
hw/dataMemory.sv
hw/spiMemory.sv
tests/spiMemoryTb.sv

// File: Makefile
TOP   = spiMemoryTb
BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir $(BUILD) -o simv

run: compile
	./$(BUILD)/simv | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf $(BUILD) sim.log

// File: tests/spiMemoryTb.sv
//------------------------------
// Testbench for the SPI slave memory, acts as the SPI master
// Reads are checked against a reference memory model
//------------------------------

`timescale 1ns/1ps
`include "spiMemory_settings.svh"

module spiMemoryTb
    import spiMemoryPkg::*;
();

    localparam int halfPeriod       = 12;  // Trigger cycles per sclk half
    localparam int randomPairs      = 40;
    localparam int transactionCount = 2 * randomPairs + 8;  // 8 directed
    localparam int timeoutLimit     = transactionCount * 18 * 2 * halfPeriod + 200;

    logic trigger;
    logic reset;
    logic sclk;
    logic chipSelect;
    logic mosi;
    logic miso;
    logic misoEnable;

    dataByte_t  refMemory [`SPI_MEMORY_DEPTH];  // Model of DUT memory
    logic [31:0] lcgState     = 32'd53;
    int          cycleCount   = 0;
    int          issuedReads  = 0;
    int          checkedReads = 0;
    logic        expectEnableLow = 1'b0;  // Write or read command in progress
    dataByte_t   expectQueue[$];
    dataByte_t   gotQueue[$];
    logic [`SPI_ADDRESS_BITS-1:0] addressQueue[$];
    event        readDone;

    spiMemory dut_i (
        .trigger(trigger), .reset(reset), .sclk(sclk), .chipSelect(chipSelect),
        .mosi(mosi), .miso(miso), .misoEnable(misoEnable)
    );

    initial begin
        trigger = 1'b0;
        forever #50 trigger = ~trigger;  // 100 ns period
    end

    // Hang guard
    always @(posedge trigger) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycleCount);
            $display("Test failed");
            $fatal(1, "run aborted");
        end
    end

    // Helpers ----------------
    function automatic dataByte_t randomByte();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];  // Upper bits mix better
    endfunction

    // What a read should return given all writes so far
    function automatic dataByte_t expectedRead(input logic [`SPI_ADDRESS_BITS-1:0] address);
        return refMemory[address];
    endfunction

    task automatic checkByte(input string name, input dataByte_t expected, input dataByte_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic checkEnable(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic waitCycles(input int count);
        repeat (count) @(posedge trigger);
        #1;  // Drive point, just after the edge
    endtask

    // misoEnable stays low outside a read's data byte
    always @(negedge trigger) begin
        if (expectEnableLow) begin
            checkEnable("misoEnable", 1'b0, misoEnable);
        end
    end

    // SPI master ----------------
    // glitchAt picks a bit whose low phase gets a 2-cycle sclk spike
    task automatic shiftByte(input dataByte_t sendByte, input logic expectEnable,
                             input int glitchAt, input int bitCount, output dataByte_t gotByte);
        dataByte_t outBits;
        outBits = sendByte;
        gotByte = '0;
        for (int n = 0; n < bitCount; n++) begin
            mosi    = outBits[7];  // MSB first, set while sclk low
            outBits = outBits << 1;
            if (n == glitchAt) begin
                waitCycles(4);
                sclk = 1'b1;  // Shorter than debounce wait
                waitCycles(2);
                sclk = 1'b0;
                waitCycles(halfPeriod - 6);
            end else begin
                waitCycles(halfPeriod);
            end
            gotByte = {gotByte[6:0], miso};  // Sample at rising sclk
            checkEnable("misoEnable", expectEnable, misoEnable);
            sclk = 1'b1;
            waitCycles(halfPeriod);
            sclk = 1'b0;
        end
    endtask

    // Fewer than 8 data bits means chipSelect rises mid-byte
    task automatic writeTransaction(input logic [`SPI_ADDRESS_BITS-1:0] address,
                                    input dataByte_t data, input int dataBits);
        commandByte_t command;
        dataByte_t    unused;
        command.address      = address;
        command.readNotWrite = 1'b0;
        expectEnableLow = 1'b1;
        chipSelect = 1'b0;
        shiftByte(dataByte_t'(command), 1'b0, -1, 8, unused);
        shiftByte(data, 1'b0, -1, dataBits, unused);
        if (dataBits == 8) begin
            waitCycles(halfPeriod);
            refMemory[address] = data;
        end
        chipSelect = 1'b1;
        waitCycles(halfPeriod);  // Gap between transactions
        expectEnableLow = 1'b0;
    endtask

    task automatic readTransaction(input logic [`SPI_ADDRESS_BITS-1:0] address,
                                   input int glitchAt);
        commandByte_t command;
        dataByte_t    unused;
        dataByte_t    got;
        command.address      = address;
        command.readNotWrite = 1'b1;
        expectEnableLow = 1'b1;
        chipSelect = 1'b0;
        shiftByte(dataByte_t'(command), 1'b0, glitchAt, 8, unused);
        expectEnableLow = 1'b0;
        shiftByte(8'h00, 1'b1, -1, 8, got);  // Slave drives miso here
        expectQueue.push_back(expectedRead(address));
        addressQueue.push_back(address);
        gotQueue.push_back(got);
        issuedReads++;
        -> readDone;
        waitCycles(halfPeriod);
        chipSelect = 1'b1;
        waitCycles(halfPeriod);
    endtask

    // Read compare ----------------
    initial begin : compareReads
        dataByte_t expected;
        dataByte_t got;
        logic [`SPI_ADDRESS_BITS-1:0] address;
        forever begin
            @(readDone);
            while (gotQueue.size() != 0) begin
                expected = expectQueue.pop_front();
                address  = addressQueue.pop_front();
                got      = gotQueue.pop_front();
                checkByte($sformatf("miso byte from address %h", address), expected, got);
                checkedReads++;
            end
        end
    end

    // Stimulus ----------------
    initial begin : stimulus
        dataByte_t rnd;
        dataByte_t randomData;
        logic [`SPI_ADDRESS_BITS-1:0] writeAddress;
        logic [`SPI_ADDRESS_BITS-1:0] readAddress;
        for (int i = 0; i < `SPI_MEMORY_DEPTH; i++) begin
            refMemory[i] = '0;  // DUT memory clears on reset
        end
        reset      = 1'b1;
        sclk       = 1'b0;
        chipSelect = 1'b1;  // Deselected
        mosi       = 1'b0;
        repeat (10) @(posedge trigger);
        #1 reset = 1'b0;
        waitCycles(4);

        readTransaction(7'h05, -1);  // Never written
        writeTransaction(7'h12, 8'hA5, 8);
        readTransaction(7'h12, -1);
        // Aborted write must leave the old byte
        writeTransaction(7'h30, 8'h3C, 8);
        writeTransaction(7'h30, 8'hFF, 4);
        readTransaction(7'h30, -1);
        // Spike during command bit 3
        writeTransaction(7'h55, 8'h96, 8);
        readTransaction(7'h55, 3);

        // 32 addresses, so 40 writes must overwrite some
        for (int n = 0; n < randomPairs; n++) begin
            rnd          = randomByte();
            writeAddress = rnd[`SPI_ADDRESS_BITS-1:0] & 7'h1F;
            randomData   = randomByte();
            writeTransaction(writeAddress, randomData, 8);
            rnd          = randomByte();
            readAddress  = rnd[`SPI_ADDRESS_BITS-1:0] & 7'h1F;
            readTransaction(readAddress, -1);
        end

        waitCycles(1);  // Let the last compare finish
        if (checkedReads == issuedReads) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Only %0d of %0d reads were compared", checkedReads, issuedReads);
            $display("Test failed");
            $fatal(1, "run aborted");
        end
    end

endmodule

// File: hw/spiMemory.sv
//------------------------------
// SPI slave memory top, pins in and miso out
// misoEnable marks when the slave drives miso
//------------------------------

`timescale 1ns/1ps
`include "spiMemory_settings.svh"

module spiMemory
    import spiMemoryPkg::*;
(
    input  logic trigger,
    input  logic reset,
    input  logic sclk,        // SPI clock from master
    input  logic chipSelect,  // Active low select
    input  logic mosi,
    output logic miso,
    output logic misoEnable
);

    logic sclkRising, sclkFalling;
    logic chipSelectLevel, chipSelectRising;
    logic mosiLevel;
    logic shiftEnable, memLoad, memWrite, addressLatch, misoUpdate;
    logic serialOut;
    shiftWord_t shiftWord;
    dataByte_t  readData;
    logic [`SPI_ADDRESS_BITS-1:0] address;  // Latched from command

    // Pin conditioning ----------------
    inputConditioner sclkCond_i (
        .trigger(trigger), .reset(reset), .resetValue(1'b0), .pin(sclk),
        .conditioned(), .risingEdge(sclkRising), .fallingEdge(sclkFalling)
    );
    inputConditioner chipSelectCond_i (
        .trigger(trigger), .reset(reset), .resetValue(1'b1), .pin(chipSelect),
        .conditioned(chipSelectLevel), .risingEdge(chipSelectRising), .fallingEdge()
    );
    inputConditioner mosiCond_i (
        .trigger(trigger), .reset(reset), .resetValue(1'b0), .pin(mosi),
        .conditioned(mosiLevel), .risingEdge(), .fallingEdge()
    );

    // Datapath ----------------
    shiftRegister shift_i (
        .trigger(trigger), .reset(reset), .shiftEnable(shiftEnable),
        .loadEnable(memLoad), .serialIn(mosiLevel), .parallelIn(readData),
        .parallelOut(shiftWord), .serialOut(serialOut)
    );

    spiControl control_i (
        .trigger(trigger), .reset(reset), .sclkRising(sclkRising),
        .sclkFalling(sclkFalling), .chipSelectLow(!chipSelectLevel),
        .chipSelectRising(chipSelectRising), .command(shiftWord.command),
        .shiftEnable(shiftEnable), .memLoad(memLoad), .memWrite(memWrite),
        .addressLatch(addressLatch), .misoEnable(misoEnable), .misoUpdate(misoUpdate)
    );

    dataMemory memory_i (
        .trigger(trigger), .reset(reset), .writeEnable(memWrite), .address(address),
        .writeData(shiftWord.data), .readData(readData)
    );

    always_ff @(posedge trigger) begin
        if (addressLatch) address <= shiftWord.command.address;  // Held for whole transaction
    end

    // Miso changes on falling sclk, master samples on rising
    always_ff @(posedge trigger) begin
        if (reset) begin
            miso <= 1'b0;
        end else if (misoUpdate) begin
            miso <= serialOut;
        end
    end

endmodule

// File: hw/dataMemory.sv
//------------------------------
// 128 x 8 memory, clocked write and combinational read
// All words clear on reset
//------------------------------

`timescale 1ns/1ps
`include "spiMemory_settings.svh"

module dataMemory
    import spiMemoryPkg::*;
(
    input  logic                         trigger,
    input  logic                         reset,
    input  logic                         writeEnable,
    input  logic [`SPI_ADDRESS_BITS-1:0] address,
    input  dataByte_t                    writeData,
    output dataByte_t                    readData
);

    dataByte_t memory [`SPI_MEMORY_DEPTH];

    always_ff @(posedge trigger) begin
        if (reset) begin
            for (int i = 0; i < `SPI_MEMORY_DEPTH; i++) begin
                memory[i] <= '0;  // Unwritten words read as zero
            end
        end else if (writeEnable) begin
            memory[address] <= writeData;
        end
    end

    assign readData = memory[address];  // Ready by the load cycle

    // Latched address must be settled before any store
    assert property (@(posedge trigger) disable iff (reset) writeEnable |-> !$isunknown(address));

endmodule

// File: hw/spiControl.sv
//------------------------------
// Transaction FSM, one command byte then one data byte
// Drives shift, load, address latch, memory write and miso strobes
//------------------------------

`timescale 1ns/1ps

module spiControl
    import spiMemoryPkg::*;
(
    input  logic         trigger,
    input  logic         reset,
    input  logic         sclkRising,       // Conditioned sclk edges
    input  logic         sclkFalling,
    input  logic         chipSelectLow,    // Selected level
    input  logic         chipSelectRising, // End or abort
    input  commandByte_t command,          // Command view of shift word
    output logic         shiftEnable,
    output logic         memLoad,
    output logic         memWrite,
    output logic         addressLatch,
    output logic         misoEnable,       // Slave owns miso
    output logic         misoUpdate        // Miso register takes serialOut
);

    controlState_t state;
    controlState_t nextState;
    logic [2:0]    bitCount;  // Bits seen in current byte
    logic          lastBit;

    assign lastBit = (bitCount == 3'd7);

    // Next state ----------------
    always_comb begin
        nextState = state;
        if (chipSelectRising) begin
            nextState = idle;  // Deselect aborts anything
        end else begin
            case (state)
                idle:         if (chipSelectLow) nextState = getCommand;
                getCommand:   if (sclkRising && lastBit) nextState = decide;
                decide: begin
                    if (command.readNotWrite) begin
                        nextState = readLoad;
                    end else begin
                        nextState = writeReceive;
                    end
                end
                readLoad:     nextState = readShift;  // Byte now in shifter
                readShift:    if (sclkRising && lastBit) nextState = finish;
                writeReceive: if (sclkRising && lastBit) nextState = writeStore;
                writeStore:   nextState = finish;
                finish:       if (!chipSelectLow) nextState = idle;
                default:      nextState = idle;
            endcase
        end
    end

    // Strobes, decoded from state
    assign shiftEnable  = sclkRising && ((state == getCommand) || (state == readShift) ||
                                         (state == writeReceive));
    assign addressLatch = (state == decide);
    assign memLoad      = (state == readLoad);
    assign memWrite     = (state == writeStore) && !chipSelectRising;
    assign misoUpdate   = (state == readShift) && sclkFalling;

    // Registers ----------------
    always_ff @(posedge trigger) begin
        if (reset) begin
            state      <= idle;
            bitCount   <= '0;
            misoEnable <= 1'b0;
        end else begin
            state <= nextState;
            if (nextState == idle) begin
                bitCount <= '0;  // Abort leaves a partial count
            end else if (shiftEnable) begin
                bitCount <= bitCount + 1'b1;  // Wraps to 0 after a byte
            end
            // On from first falling edge, off on leaving readShift
            misoEnable <= (nextState == readShift) && (misoEnable || sclkFalling);
        end
    end

    // Checks ----------------
    assert property (@(posedge trigger) disable iff (reset) !(memWrite && memLoad));
    assert property (@(posedge trigger) disable iff (reset) misoEnable |-> state == readShift);

endmodule

// File: hw/shiftRegister.sv
//------------------------------
// 8-bit shift register, serial in at the LSB and out at the MSB
// Parallel load wins over shift
//------------------------------

`timescale 1ns/1ps

module shiftRegister
    import spiMemoryPkg::*;
(
    input  logic       trigger,
    input  logic       reset,
    input  logic       shiftEnable,  // Take serialIn this cycle
    input  logic       loadEnable,   // Take parallelIn this cycle
    input  logic       serialIn,
    input  dataByte_t  parallelIn,
    output shiftWord_t parallelOut,  // Command or data view
    output logic       serialOut     // MSB, goes toward miso
);

    // Register ----------------
    always_ff @(posedge trigger) begin
        if (reset) begin
            parallelOut <= '0;
        end else if (loadEnable) begin
            parallelOut.data <= parallelIn;  // Memory byte for a read
        end else if (shiftEnable) begin
            // MSB first on the wire, so old bits move up
            parallelOut.data <= {parallelOut.data[6:0], serialIn};
        end
    end

    // Next bit to send is always the top one
    assign serialOut = parallelOut.data[7];

endmodule

// File: hw/inputConditioner.sv
//------------------------------
// Synchronizer, debouncer and edge detector for one async pin
// resetValue sets the idle level the output starts from
//------------------------------

`timescale 1ns/1ps
`include "spiMemory_settings.svh"

module inputConditioner (
    input  logic trigger,
    input  logic reset,
    input  logic resetValue,   // Idle level of the pin
    input  logic pin,          // Raw async input
    output logic conditioned,  // Clean level
    output logic risingEdge,   // One-cycle pulse on 0 -> 1
    output logic fallingEdge   // One-cycle pulse on 1 -> 0
);

    // Counter value on the last stable cycle
    localparam logic [`SPI_DEBOUNCE_BITS-1:0] lastCount =
        `SPI_DEBOUNCE_BITS'(`SPI_DEBOUNCE_WAIT - 1);

    logic syncFirst;   // Metastability stage
    logic syncSecond;  // Safe to use
    logic [`SPI_DEBOUNCE_BITS-1:0] counter;

    always_ff @(posedge trigger) begin
        if (reset) begin
            syncFirst   <= resetValue;
            syncSecond  <= resetValue;
            conditioned <= resetValue;
            counter     <= '0;
            risingEdge  <= 1'b0;
            fallingEdge <= 1'b0;
        end else begin
            syncFirst   <= pin;
            syncSecond  <= syncFirst;
            risingEdge  <= 1'b0;  // Pulses by default
            fallingEdge <= 1'b0;
            if (syncSecond == conditioned) begin
                counter <= '0;  // Glitch gone, start over
            end else if (counter == lastCount) begin
                conditioned <= syncSecond;  // Held long enough
                counter     <= '0;
                risingEdge  <= syncSecond;
                fallingEdge <= ~syncSecond;
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    // Edge pulses ----------------
    assert property (@(posedge trigger) disable iff (reset) !(risingEdge && fallingEdge));
    assert property (@(posedge trigger) disable iff (reset) risingEdge |=> !risingEdge);
    assert property (@(posedge trigger) disable iff (reset) fallingEdge |=> !fallingEdge);

endmodule

// File: hw/spiMemoryPkg.sv
//------------------------------
// Shared types for the SPI slave memory
// Import with spiMemoryPkg::* in the module header
//------------------------------

`include "spiMemory_settings.svh"

package spiMemoryPkg;

    // One byte on the wire or in memory
    typedef logic [7:0] dataByte_t;

    // Command byte, MSB first on mosi
    typedef struct packed {
        logic [`SPI_ADDRESS_BITS-1:0] address;  // Target word
        logic                         readNotWrite; // 1 = read
    } commandByte_t;

    // Shift register contents, command after byte 1 and data after byte 2
    typedef union packed {
        commandByte_t command;
        dataByte_t    data;
    } shiftWord_t;

    // Transaction FSM
    typedef enum logic [2:0] {
        idle, getCommand, decide, readLoad,
        readShift, writeReceive, writeStore, finish
    } controlState_t;

endpackage

// File: hw/spiMemory_settings.svh
//------------------------------
// Build-time sizes for the SPI slave memory
// Include wherever a width or depth is needed
//------------------------------

`ifndef SPI_MEMORY_SETTINGS_SVH
`define SPI_MEMORY_SETTINGS_SVH

// Input conditioner
`define SPI_DEBOUNCE_WAIT 3   // Stable cycles before output follows
`define SPI_DEBOUNCE_BITS 2   // Must hold SPI_DEBOUNCE_WAIT - 1

// Memory geometry
`define SPI_ADDRESS_BITS  7   // Command byte carries 7 address bits
`define SPI_MEMORY_DEPTH  128 // 2**SPI_ADDRESS_BITS words

`endif
